// File: source/psram_pkg.sv
`default_nettype none

package psram_pkg;

    // the bus carries a word address: 8M words, bits 22:21 pick the chip.
    localparam int addr_bits = 23;

    localparam int data_bits = 32;

    // wide enough to hold a full word length of 32 bits.
    localparam int count_bits = 6;

    // single-line opcodes.
    localparam logic [7:0] cmd_read = 8'h03;
    localparam logic [7:0] cmd_write = 8'h02;

    // quad opcodes; command byte itself still goes out on one line.
    localparam logic [7:0] cmd_fast_read_quad = 8'heb;
    localparam logic [7:0] cmd_quad_write = 8'h38;

    // sclk periods between the address and the first read nibble.
    localparam int dummy_clocks = 6;

endpackage

`default_nettype wire

// File: source/psram_write_align.sv
`default_nettype none
`timescale 1ns/100ps

module psram_write_align import psram_pkg::*; (
    input  wire  [3:0]            wstrb,
    input  wire  [data_bits-1:0]  wdata,
    output logic [1:0]            byte_offset,
    output logic [count_bits-1:0] wr_bits,
    output logic [data_bits-1:0]  wr_word
);

    // the psram stores bytes big-endian, so lane 0 sits at byte offset 3.
    always_comb begin
        wr_word = wdata;
        case (wstrb)
            4'b0001: begin
                byte_offset = 2'd3;
                wr_bits = 6'd8;
                wr_word[31:24] = wdata[7:0];
            end
            4'b0010: begin
                byte_offset = 2'd2;
                wr_bits = 6'd8;
                wr_word[31:24] = wdata[15:8];
            end
            4'b0100: begin
                byte_offset = 2'd1;
                wr_bits = 6'd8;
                wr_word[31:24] = wdata[23:16];
            end
            4'b1000: begin
                byte_offset = 2'd0;
                wr_bits = 6'd8;
                wr_word[31:24] = wdata[31:24];
            end
            4'b0011: begin
                byte_offset = 2'd2;
                wr_bits = 6'd16;
                wr_word[31:16] = wdata[15:0];
            end
            4'b1100: begin
                byte_offset = 2'd0;
                wr_bits = 6'd16;
                wr_word[31:16] = wdata[31:16];
            end
            4'b1111: begin
                byte_offset = 2'd0;
                wr_bits = 6'd32;
            end
            // odd strobe patterns fall back to a full word write.
            default: begin
                byte_offset = 2'd0;
                wr_bits = 6'd32;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/spi_shifter.sv
`default_nettype none
`timescale 1ns/100ps

module spi_shifter import psram_pkg::*; (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire                   load,
    input  wire  [data_bits-1:0]  load_word,
    input  wire  [count_bits-1:0] load_bits,
    input  wire                   quad,
    input  wire  [3:0]            sio_in,
    output logic                  busy,
    output logic [data_bits-1:0]  word,
    output logic                  sclk,
    output logic [3:0]            sio_out
);

    logic [data_bits-1:0]  shreg;
    logic [count_bits-1:0] count;
    logic [count_bits-1:0] step;
    logic                  quad_r;
    // low half of the sclk period when clear, high half when set.
    logic                  phase;

    assign busy = (count != '0);
    assign word = shreg;
    assign step = quad_r ? 6'd4 : 6'd1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
            quad_r <= 1'b0;
            phase <= 1'b0;
            sclk <= 1'b0;
            sio_out <= 4'b0000;
        end else if (load) begin
            count <= load_bits;
            quad_r <= quad;
            phase <= 1'b0;
        end else if (busy) begin
            if (!phase) begin
                // falling edge: present the next bits to the device.
                sclk <= 1'b0;
                sio_out <= quad_r ? shreg[data_bits-1 -: 4] : {3'b000, shreg[data_bits-1]};
                phase <= 1'b1;
            end else begin
                sclk <= 1'b1;
                count <= count - step;
                phase <= 1'b0;
            end
        end else begin
            sclk <= 1'b0;
        end
    end

    // the rising-edge half also captures what the device drove.
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= load_word;
        end else if (busy && phase) begin
            if (quad_r) begin
                shreg <= {shreg[data_bits-5:0], sio_in};
            end else begin
                // single-line mode reads back on so, which is sio1.
                shreg <= {shreg[data_bits-2:0], sio_in[1]};
            end
        end
    end

endmodule

`default_nettype wire

// File: source/psram_sequencer.sv
`default_nettype none
`timescale 1ns/100ps

module psram_sequencer import psram_pkg::*; #(
    parameter bit quad_mode = 1'b1
) (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire                   valid,
    input  wire  [addr_bits-1:0]  addr,
    input  wire  [3:0]            wstrb,
    input  wire  [1:0]            byte_offset,
    input  wire  [count_bits-1:0] wr_bits,
    input  wire  [data_bits-1:0]  wr_word,
    output logic                  ready,
    output logic [data_bits-1:0]  rdata,
    output logic                  ce_n,
    output logic [1:0]            cs,
    output logic [3:0]            sio_oe,
    output logic                  load,
    output logic [data_bits-1:0]  load_word,
    output logic [count_bits-1:0] load_bits,
    output logic                  quad,
    input  wire                   busy,
    input  wire  [data_bits-1:0]  word
);

    typedef enum logic [2:0] {
        st_idle,
        st_select,
        st_command,
        st_address,
        st_dummy,
        st_data,
        st_done
    } state_t;

    state_t state;

    logic       write;
    logic [7:0] opcode;
    logic [1:0] addr_offset;

    assign write = |wstrb;
    assign addr_offset = write ? byte_offset : 2'b00;

    always_comb begin
        if (quad_mode) begin
            opcode = write ? cmd_quad_write : cmd_fast_read_quad;
        end else begin
            opcode = write ? cmd_write : cmd_read;
        end
    end

    // a phase is handed to the shifter on the same edge the state moves on,
    // so the following state already sees busy high in its first cycle.
    always_comb begin
        load = 1'b0;
        load_word = '0;
        load_bits = '0;
        quad = 1'b0;
        case (state)
            st_command: begin
                load = !busy;
                load_word = {opcode, 24'h000000};
                load_bits = 6'd8;
            end
            st_address: begin
                load = !busy;
                load_word = {1'b0, addr[addr_bits-3:0], addr_offset, 8'h00};
                load_bits = 6'd24;
                quad = quad_mode;
            end
            st_dummy: begin
                load = !busy;
                load_bits = 6'(dummy_clocks);
            end
            st_data: begin
                load = !busy;
                load_word = write ? wr_word : '0;
                load_bits = write ? wr_bits : 6'(data_bits);
                quad = quad_mode;
            end
            default: begin
                load = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
            ready <= 1'b0;
            ce_n <= 1'b1;
            cs <= 2'b00;
            sio_oe <= 4'b1111;
        end else begin
            case (state)
                st_idle: begin
                    ce_n <= 1'b1;
                    if (valid && !ready) begin
                        state <= st_select;
                    end else if (!valid) begin
                        ready <= 1'b0;
                    end
                end
                st_select: begin
                    cs <= addr[addr_bits-1 -: 2];
                    ce_n <= 1'b0;
                    sio_oe <= 4'b0001;
                    state <= st_command;
                end
                st_command: begin
                    if (!busy) begin
                        state <= st_address;
                    end
                end
                st_address: begin
                    if (!busy) begin
                        sio_oe <= 4'b1111;
                        state <= (quad_mode && !write) ? st_dummy : st_data;
                    end
                end
                st_dummy: begin
                    if (!busy) begin
                        sio_oe <= 4'b0000;
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (!busy) begin
                        sio_oe <= write ? 4'b1111 : 4'b0000;
                        state <= st_done;
                    end
                end
                st_done: begin
                    if (!busy) begin
                        ready <= 1'b1;
                        sio_oe <= 4'b1111;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_done && !busy) begin
            rdata <= word;
        end
    end

endmodule

`default_nettype wire

// File: source/psram_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module psram_ctrl import psram_pkg::*; #(
    parameter bit quad_mode = 1'b1
) (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  valid,
    output logic                 ready,
    input  wire  [addr_bits-1:0] addr,
    input  wire  [data_bits-1:0] wdata,
    input  wire  [3:0]           wstrb,
    output logic [data_bits-1:0] rdata,
    output logic                 ce_n,
    output logic [1:0]           cs,
    output logic                 sclk,
    output logic [3:0]           sio_out,
    output logic [3:0]           sio_oe,
    input  wire  [3:0]           sio_in
);

    logic [1:0]            byte_offset;
    logic [count_bits-1:0] wr_bits;
    logic [data_bits-1:0]  wr_word;
    logic                  load;
    logic [data_bits-1:0]  load_word;
    logic [count_bits-1:0] load_bits;
    logic                  quad;
    logic                  busy;
    logic [data_bits-1:0]  word;

    psram_write_align psram_write_align_i (
        .wstrb       (wstrb),
        .wdata       (wdata),
        .byte_offset (byte_offset),
        .wr_bits     (wr_bits),
        .wr_word     (wr_word)
    );

    psram_sequencer #(
        .quad_mode (quad_mode)
    ) psram_sequencer_i (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .addr        (addr),
        .wstrb       (wstrb),
        .byte_offset (byte_offset),
        .wr_bits     (wr_bits),
        .wr_word     (wr_word),
        .ready       (ready),
        .rdata       (rdata),
        .ce_n        (ce_n),
        .cs          (cs),
        .sio_oe      (sio_oe),
        .load        (load),
        .load_word   (load_word),
        .load_bits   (load_bits),
        .quad        (quad),
        .busy        (busy),
        .word        (word)
    );

    spi_shifter spi_shifter_i (
        .clk       (clk),
        .resetn    (resetn),
        .load      (load),
        .load_word (load_word),
        .load_bits (load_bits),
        .quad      (quad),
        .sio_in    (sio_in),
        .busy      (busy),
        .word      (word),
        .sclk      (sclk),
        .sio_out   (sio_out)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock #(
    parameter int period_ns = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: verification/psram_model.sv
`default_nettype none
`timescale 1ns/100ps

module psram_model import psram_pkg::*; #(
    parameter bit quad_mode = 1'b1
) (
    input  wire        ce_n,
    input  wire  [1:0] cs,
    input  wire        sclk,
    input  wire  [3:0] sio_out,
    input  wire  [3:0] sio_oe,
    output logic [3:0] sio_in,
    output int         frame_count,
    output int         last_write_bits,
    output int         errors
);

    localparam int addr_clocks = quad_mode ? 6 : 24;
    localparam int read_start = 8 + addr_clocks + (quad_mode ? dummy_clocks : 0);
    localparam int data_clocks = quad_mode ? 8 : 32;
    localparam logic [7:0] op_read = quad_mode ? cmd_fast_read_quad : cmd_read;
    localparam logic [7:0] op_write = quad_mode ? cmd_quad_write : cmd_write;

    logic [7:0]  mem [logic [25:0]];
    logic [3:0]  drive = 4'b0000;
    logic [3:0]  bus;
    logic [1:0]  chip;
    logic [7:0]  opcode;
    logic [23:0] byte_addr;
    logic [31:0] wr_data;
    int          rises;
    int          wr_bits;
    int          frames = 0;
    int          last_bits = 0;
    int          errs = 0;

    // each line carries the controller where it drives and the device elsewhere.
    assign bus = (sio_out & sio_oe) | (drive & ~sio_oe);
    assign sio_in = bus;
    assign frame_count = frames;
    assign last_write_bits = last_bits;
    assign errors = errs;

    function automatic logic [7:0] stored_byte(input int index);
        logic [25:0] key;
        key = {chip, byte_addr + 24'(index)};
        return mem.exists(key) ? mem[key] : 8'h00;
    endfunction

    // one pass per frame; bits are taken on the rising sclk.
    always begin
        @(negedge ce_n);
        rises = 0;
        wr_bits = 0;
        opcode = 8'h00;
        byte_addr = 24'h000000;
        wr_data = 32'h00000000;
        while (ce_n === 1'b0) begin
            @(posedge sclk or posedge ce_n);
            if (ce_n === 1'b0) begin
                if (rises == 0) begin
                    chip = cs;
                end
                if (rises < 8) begin
                    opcode = {opcode[6:0], bus[0]};
                end else if (rises < 8 + addr_clocks) begin
                    byte_addr = quad_mode ? {byte_addr[19:0], bus} : {byte_addr[22:0], bus[0]};
                end else if (opcode == op_write) begin
                    wr_data = quad_mode ? {wr_data[27:0], bus} : {wr_data[30:0], bus[0]};
                    wr_bits += quad_mode ? 4 : 1;
                end
                rises++;
            end
        end
        assert (opcode == op_read || opcode == op_write) else begin
            errs++;
            $display("error: opcode = %h, expected %h or %h", opcode, op_read, op_write);
        end
        if (opcode == op_write) begin
            assert (wr_bits == 8 || wr_bits == 16 || wr_bits == 32) else begin
                errs++;
                $display("error: write data bits = %h, expected 08, 10 or 20", wr_bits);
            end
            for (int i = 0; i < wr_bits / 8 && i < 4; i++) begin
                mem[{chip, byte_addr + 24'(i)}] = wr_data[wr_bits - 1 - 8 * i -: 8];
            end
            last_bits = wr_bits;
        end
        frames++;
    end

    // read data goes out on the falling sclk, first byte first.
    always @(negedge sclk) begin
        int n;
        logic [7:0] b;
        if (ce_n === 1'b0 && opcode == op_read && rises >= read_start &&
            rises < read_start + data_clocks) begin
            n = rises - read_start;
            if (quad_mode) begin
                b = stored_byte(n / 2);
                drive = n[0] ? b[3:0] : b[7:4];
            end else begin
                b = stored_byte(n / 8);
                drive = {2'b00, b[7 - n % 8], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/psram_ctrl_tb.sv
`default_nettype none
`timescale 1ns/100ps

module psram_ctrl_tb import psram_pkg::*; ();

    localparam bit quad_mode = 1'b1;
    localparam int word_pairs = 24;
    localparam int num_transactions = 2 * word_pairs + 8 * 3 + 2 * 8 + 2;
    localparam int watchdog_ns = (num_transactions + 2) * 200 * 8;
    localparam int ready_limit = 200;

    logic                 clk;
    logic                 resetn;
    logic                 valid;
    logic                 ready;
    logic [addr_bits-1:0] addr;
    logic [data_bits-1:0] wdata;
    logic [3:0]           wstrb;
    logic [data_bits-1:0] rdata;
    logic                 ce_n;
    logic [1:0]           cs;
    logic                 sclk;
    logic [3:0]           sio_out;
    logic [3:0]           sio_oe;
    logic [3:0]           sio_in;
    int                   frame_count;
    int                   last_write_bits;
    int                   model_errors;
    int                   check_errors = 0;
    int                   monitor_errors = 0;
    int                   seed = 88;
    logic                 ready_q = 1'b0;
    logic                 valid_q = 1'b0;
    logic [7:0]           ref_mem [logic [25:0]];
    logic [3:0]           strobe_patterns [8] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                                  4'b0011, 4'b1100, 4'b1111, 4'b0101};

    tb_clock #(.period_ns(8)) tb_clock_i (.clk(clk));

    psram_ctrl #(
        .quad_mode (quad_mode)
    ) psram_ctrl_i (
        .clk     (clk),
        .resetn  (resetn),
        .valid   (valid),
        .ready   (ready),
        .addr    (addr),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .rdata   (rdata),
        .ce_n    (ce_n),
        .cs      (cs),
        .sclk    (sclk),
        .sio_out (sio_out),
        .sio_oe  (sio_oe),
        .sio_in  (sio_in)
    );

    psram_model #(
        .quad_mode (quad_mode)
    ) psram_model_i (
        .ce_n            (ce_n),
        .cs              (cs),
        .sclk            (sclk),
        .sio_out         (sio_out),
        .sio_oe          (sio_oe),
        .sio_in          (sio_in),
        .frame_count     (frame_count),
        .last_write_bits (last_write_bits),
        .errors          (model_errors)
    );

    // byte i of a word sits at byte address {addr[20:0], i} of its chip.
    function automatic logic [25:0] byte_key(input logic [22:0] a, input int i);
        return {a[22:21], 1'b0, a[20:0], 2'(i)};
    endfunction

    // patterns outside the byte and half-word set write the whole word.
    function automatic logic [3:0] written_lanes(input logic [3:0] s);
        case (s)
            4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100: return s;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] ref_read(input logic [22:0] a);
        logic [31:0] w;
        logic [25:0] k;
        for (int i = 0; i < 4; i++) begin
            k = byte_key(a, i);
            w[31 - 8 * i -: 8] = ref_mem.exists(k) ? ref_mem[k] : 8'h00;
        end
        return w;
    endfunction

    // lane 0 holds the byte with the highest address of the word.
    task automatic ref_write(input logic [22:0] a, input logic [31:0] d, input logic [3:0] s);
        logic [3:0] lanes;
        lanes = written_lanes(s);
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                ref_mem[byte_key(a, 3 - i)] = d[8 * i +: 8];
            end
        end
    endtask

    function automatic logic [22:0] random_addr();
        int r;
        r = $random(seed);
        return r[22:0];
    endfunction

    task automatic transfer(input logic [22:0] a, input logic [31:0] d, input logic [3:0] s,
                            input int hold);
        int waited;
        int frames_before;
        logic [31:0] expected;
        frames_before = frame_count;
        addr = a;
        wdata = d;
        wstrb = s;
        valid = 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!ready && waited < ready_limit);
        if (!ready) begin
            check_errors++;
            $display("no ready within %0d cycles for addr %h", ready_limit, a);
        end
        if (s == 4'b0000) begin
            expected = ref_read(a);
            assert (rdata == expected) else begin
                check_errors++;
                $display("error: rdata = %h, expected %h at addr %h", rdata, expected, a);
            end
        end else begin
            ref_write(a, d, s);
        end
        repeat (hold) begin
            @(posedge clk);
            #1;
            assert (ready && ce_n) else begin
                check_errors++;
                $display("error: ready = %h, ce_n = %h while valid was held", ready, ce_n);
            end
        end
        valid = 1'b0;
        @(posedge clk);
        #1;
        assert (!ready) else begin
            check_errors++;
            $display("error: ready = %h, expected 0 after valid dropped", ready);
        end
        assert (frame_count == frames_before + 1) else begin
            check_errors++;
            $display("error: frame_count = %h, expected %h", frame_count, frames_before + 1);
        end
        if (s != 4'b0000) begin
            expected = 32'($countones(written_lanes(s)) * 8);
            assert (last_write_bits == int'(expected)) else begin
                check_errors++;
                $display("error: write bits = %h, expected %h", last_write_bits, expected);
            end
        end
    endtask

    // a rise of ready shows up one edge late, so it is judged against valid of that edge.
    always @(posedge clk) begin
        if (resetn) begin
            assert (valid_q || !ready || ready_q) else begin
                monitor_errors++;
                $display("ready rose at %0t while valid was low", $time);
            end
            assert (ce_n || cs == addr[22:21]) else begin
                monitor_errors++;
                $display("error: cs = %h, expected %h", cs, addr[22:21]);
            end
        end
        ready_q <= ready;
        valid_q <= valid;
    end

    initial begin
        logic [22:0] a;
        resetn = 1'b0;
        valid = 1'b0;
        addr = '0;
        wdata = '0;
        wstrb = 4'b0000;
        repeat (5) @(posedge clk);
        #1;
        assert (ce_n && !ready && !sclk) else begin
            check_errors++;
            $display("error: reset ce_n = %h, ready = %h, sclk = %h", ce_n, ready, sclk);
        end
        assert (cs == 2'b00 && sio_oe == 4'b1111 && sio_out == 4'b0000) else begin
            check_errors++;
            $display("error: reset cs = %h, sio_oe = %h, sio_out = %h", cs, sio_oe, sio_out);
        end
        resetn = 1'b1;
        repeat (10) begin
            @(posedge clk);
            #1;
            assert (ce_n && !ready && !sclk) else begin
                check_errors++;
                $display("error: idle ce_n = %h, ready = %h, sclk = %h", ce_n, ready, sclk);
            end
        end
        repeat (word_pairs) begin
            a = random_addr();
            transfer(a, $random(seed), 4'b1111, 0);
            transfer(a, 32'h0, 4'b0000, 0);
        end
        // a full word first, so the untouched lanes have known contents.
        for (int p = 0; p < 8; p++) begin
            a = random_addr();
            transfer(a, $random(seed), 4'b1111, 0);
            transfer(a, $random(seed), strobe_patterns[p], 0);
            transfer(a, 32'h0, 4'b0000, 0);
        end
        repeat (2) begin
            a = random_addr();
            for (int c = 0; c < 4; c++) begin
                transfer({2'(c), a[20:0]}, $random(seed), 4'b1111, 0);
            end
            for (int c = 0; c < 4; c++) begin
                transfer({2'(c), a[20:0]}, 32'h0, 4'b0000, 0);
            end
        end
        a = random_addr();
        transfer(a, $random(seed), 4'b1111, 6);
        transfer(a, 32'h0, 4'b0000, 6);
        $display("%0d check errors, %0d monitor errors, %0d model errors, %0d frames",
                 check_errors, monitor_errors, model_errors, frame_count);
        if (check_errors + monitor_errors + model_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout after %0d ns with %0d frames done", watchdog_ns, frame_count);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
source/psram_pkg.sv
source/psram_write_align.sv
source/spi_shifter.sv
source/psram_sequencer.sv
source/psram_ctrl.sv
verification/tb_clock.sv
verification/psram_model.sv
verification/psram_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module psram_ctrl_tb \
    -f list.f -o psram_ctrl_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/psram_ctrl_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
